// ==== hw/store_align.sv ====
// --------------------------------------------------------------------------
// Registered data rotate and byte-enable build for one store
// Stores must be naturally aligned, a misaligned offset is not corrected
// --------------------------------------------------------------------------
`default_nettype none

module store_align (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          accept_i,
  input  store_pkg::store_op_e          op_i,
  input  logic [store_pkg::DATA_W-1:0]  data_i,
  input  logic [store_pkg::PADDR_W-1:0] paddr_i,
  output logic [store_pkg::PADDR_W-1:0] addr_o,
  output logic [store_pkg::DATA_W-1:0]  wdata_o,
  output logic [store_pkg::BE_W-1:0]    be_o
);

  logic [store_pkg::OFFS_W-1:0]   offs;
  // Number of bytes and the offset bits that must be zero for it
  logic [store_pkg::OFFS_W:0]     size_bytes;
  logic [store_pkg::OFFS_W-1:0]   offs_mask;
  // Data doubled up so a plain shift gives a rotate
  logic [2*store_pkg::DATA_W-1:0] data_dbl;
  logic [store_pkg::BE_W-1:0]     be_base;

  assign offs       = paddr_i[store_pkg::OFFS_W-1:0];
  assign size_bytes = {{store_pkg::OFFS_W{1'b0}}, 1'b1} << op_i;
  assign offs_mask  = size_bytes[store_pkg::OFFS_W-1:0] - 1'b1;

  // Rotate left by eight times the byte offset
  assign data_dbl   = {data_i, data_i} << {offs, 3'b000};

  // Low-aligned mask for the access size
  always_comb begin
    case (op_i)
      store_pkg::ST_B: be_base = 8'h01;
      store_pkg::ST_H: be_base = 8'h03;
      store_pkg::ST_W: be_base = 8'h0F;
      default:         be_base = 8'hFF;
    endcase
  end

  // Payload only, qualified downstream by push
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      addr_o  <= {paddr_i[store_pkg::PADDR_W-1:store_pkg::OFFS_W], {store_pkg::OFFS_W{1'b0}}};
      wdata_o <= data_dbl[2*store_pkg::DATA_W-1:store_pkg::DATA_W];
      be_o    <= be_base << offs;
    end
  end

  // The address generator guarantees natural alignment
  a_natural_align: assert property (
    @(posedge clk_i) disable iff (!rst_ni) accept_i |-> ((offs & offs_mask) == '0));

endmodule

`default_nettype wire

// ==== hw/store_ctrl.sv ====
// --------------------------------------------------------------------------
// Issue control of the store path, MMU answers are combinational to the req
// A flush cancels the store in ST_VALID and blocks acceptance that cycle
// --------------------------------------------------------------------------
`default_nettype none

module store_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // Issue stage
  input  logic                             valid_i,
  input  logic [store_pkg::VADDR_W-1:0]    vaddr_i,
  input  logic [store_pkg::TRANS_ID_W-1:0] trans_id_i,
  output logic                             pop_o,
  // MMU
  input  logic                             dtlb_hit_i,
  input  logic                             ex_valid_i,
  output logic                             translation_req_o,
  output logic [store_pkg::VADDR_W-1:0]    vaddr_o,
  // Store queue
  input  logic                             sq_ready_i,
  output logic                             accept_o,
  output logic                             push_o,
  // Result strobe
  output logic                             valid_o,
  output logic                             ex_o,
  output logic [store_pkg::TRANS_ID_W-1:0] trans_id_o
);

  store_pkg::store_state_e          state_q, state_d;
  // Exception flag of the store in flight
  logic                             ex_q;
  logic [store_pkg::TRANS_ID_W-1:0] trans_id_q;
  logic                             accept;
  logic                             in_valid;

  assign in_valid = (state_q == store_pkg::ST_VALID);

  // The MMU translates the address that the issue stage currently presents
  assign vaddr_o    = vaddr_i;
  assign pop_o      = accept;
  assign accept_o   = accept;

  // Result of the store accepted one cycle earlier
  assign valid_o    = in_valid;
  assign ex_o       = in_valid & ex_q;
  assign trans_id_o = trans_id_q;
  // Faulting or flushed stores never reach the queue
  assign push_o     = in_valid & ~ex_q & ~flush_i;

  // --------------------------------------------------------------------------
  // Acceptance FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_d           = state_q;
    translation_req_o = 1'b0;
    accept            = 1'b0;

    case (state_q)
      // A new store may follow directly behind the one in ST_VALID
      store_pkg::ST_IDLE, store_pkg::ST_VALID: begin
        if (valid_i) begin
          translation_req_o = 1'b1;
          // An exception finishes the store, hit and space do not matter
          if (ex_valid_i || (dtlb_hit_i && sq_ready_i)) begin
            accept  = 1'b1;
            state_d = store_pkg::ST_VALID;
          end else if (!dtlb_hit_i) begin
            state_d = store_pkg::ST_WAIT_TRANS;
          end else begin
            state_d = store_pkg::ST_WAIT_READY;
          end
        end else begin
          state_d = store_pkg::ST_IDLE;
        end
      end

      // Keep asking, then retry the whole acceptance from idle
      store_pkg::ST_WAIT_TRANS, store_pkg::ST_WAIT_READY: begin
        translation_req_o = 1'b1;
        if (ex_valid_i || (dtlb_hit_i && sq_ready_i)) begin
          state_d = store_pkg::ST_IDLE;
        end
      end

      default: state_d = store_pkg::ST_IDLE;
    endcase

    // Flush wins over everything
    if (flush_i) begin
      accept  = 1'b0;
      state_d = store_pkg::ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= store_pkg::ST_IDLE;
      ex_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        ex_q <= ex_valid_i;
      end
    end
  end

  // Tag only matters while valid_o is high
  always_ff @(posedge clk_i) begin
    if (accept) begin
      trans_id_q <= trans_id_i;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  a_pop_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_o |-> valid_i);

  a_no_push_on_ex: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_o |-> !ex_o);

endmodule

`default_nettype wire

// ==== hw/store_pkg.sv ====
// --------------------------------------------------------------------------
// Shared widths, queue depth and enums of the store unit
// SQ_DEPTH must stay a power of two, the queue pointers wrap on their own
// --------------------------------------------------------------------------
`default_nettype none

package store_pkg;

  // --------------------------------------------------------------------------
  // Data path widths
  // --------------------------------------------------------------------------
  // 64-bit store data, one enable per byte
  localparam int DATA_W     = 64;
  localparam int BE_W       = DATA_W / 8;
  // Byte offset inside one data word
  localparam int OFFS_W     = 3;
  // Sv39 virtual and 34-bit physical addresses
  localparam int VADDR_W    = 39;
  localparam int PADDR_W    = 34;
  // Tag that returns with the result strobe
  localparam int TRANS_ID_W = 3;

  // --------------------------------------------------------------------------
  // Store queue geometry
  // --------------------------------------------------------------------------
  localparam int SQ_DEPTH   = 4;
  localparam int SQ_PTR_W   = 2;

  // Access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    ST_B,
    ST_H,
    ST_W,
    ST_D
  } store_op_e;

  // Issue-control states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_VALID,
    ST_WAIT_TRANS,
    ST_WAIT_READY
  } store_state_e;

endpackage

`default_nettype wire

// ==== hw/store_queue.sv ====
// --------------------------------------------------------------------------
// Circular store queue, speculative until commit, then drained in order
// ready_o reserves a slot for the push of the store already in ST_VALID
// --------------------------------------------------------------------------
`default_nettype none

module store_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  // Push from the align stage
  input  logic                          push_i,
  input  logic [store_pkg::PADDR_W-1:0] addr_i,
  input  logic [store_pkg::DATA_W-1:0]  wdata_i,
  input  logic [store_pkg::BE_W-1:0]    be_i,
  output logic                          ready_o,
  // Commit
  input  logic                          commit_i,
  output logic                          commit_ready_o,
  output logic                          store_buffer_empty_o,
  output logic                          no_st_pending_o,
  // Data memory write port
  output logic                          mem_req_o,
  output logic [store_pkg::PADDR_W-1:0] mem_addr_o,
  output logic [store_pkg::DATA_W-1:0]  mem_wdata_o,
  output logic [store_pkg::BE_W-1:0]    mem_be_o,
  input  logic                          mem_gnt_i
);

  // Entry storage
  logic [store_pkg::PADDR_W-1:0]  addr_mem  [store_pkg::SQ_DEPTH];
  logic [store_pkg::DATA_W-1:0]   wdata_mem [store_pkg::SQ_DEPTH];
  logic [store_pkg::BE_W-1:0]     be_mem    [store_pkg::SQ_DEPTH];

  // rd..cm holds committed entries, cm..wr speculative ones
  logic [store_pkg::SQ_PTR_W-1:0] rd_ptr_q, cm_ptr_q, wr_ptr_q;
  logic [store_pkg::SQ_PTR_W-1:0] rd_ptr_d, cm_ptr_d, wr_ptr_d;
  logic [store_pkg::SQ_PTR_W:0]   spec_cnt_q, spec_cnt_d;
  logic [store_pkg::SQ_PTR_W:0]   cmt_cnt_q, cmt_cnt_d;
  logic [store_pkg::SQ_PTR_W:0]   used_cnt;
  logic                           drain;

  assign used_cnt = spec_cnt_q + cmt_cnt_q;
  assign drain    = mem_req_o & mem_gnt_i;

  // Count the push in flight as taken
  assign ready_o = (used_cnt + {{store_pkg::SQ_PTR_W{1'b0}}, push_i}) < store_pkg::SQ_DEPTH;

  assign commit_ready_o       = (spec_cnt_q != '0);
  assign store_buffer_empty_o = (used_cnt == '0);
  assign no_st_pending_o      = (cmt_cnt_q == '0);

  // Oldest committed entry, stable until granted
  assign mem_req_o   = (cmt_cnt_q != '0);
  assign mem_addr_o  = addr_mem[rd_ptr_q];
  assign mem_wdata_o = wdata_mem[rd_ptr_q];
  assign mem_be_o    = be_mem[rd_ptr_q];

  // --------------------------------------------------------------------------
  // Pointer and counter update
  // --------------------------------------------------------------------------
  always_comb begin
    rd_ptr_d  = rd_ptr_q + {{(store_pkg::SQ_PTR_W-1){1'b0}}, drain};
    cm_ptr_d  = cm_ptr_q + {{(store_pkg::SQ_PTR_W-1){1'b0}}, commit_i};
    cmt_cnt_d = cmt_cnt_q + {{store_pkg::SQ_PTR_W{1'b0}}, commit_i}
                          - {{store_pkg::SQ_PTR_W{1'b0}}, drain};
    if (flush_i) begin
      // Drop all speculative entries, a same-cycle commit still counts
      wr_ptr_d   = cm_ptr_d;
      spec_cnt_d = '0;
    end else begin
      wr_ptr_d   = wr_ptr_q + {{(store_pkg::SQ_PTR_W-1){1'b0}}, push_i};
      spec_cnt_d = spec_cnt_q + {{store_pkg::SQ_PTR_W{1'b0}}, push_i}
                              - {{store_pkg::SQ_PTR_W{1'b0}}, commit_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      cm_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      spec_cnt_q <= '0;
      cmt_cnt_q  <= '0;
    end else begin
      rd_ptr_q   <= rd_ptr_d;
      cm_ptr_q   <= cm_ptr_d;
      wr_ptr_q   <= wr_ptr_d;
      spec_cnt_q <= spec_cnt_d;
      cmt_cnt_q  <= cmt_cnt_d;
    end
  end

  // Push lands in the slot behind the newest entry
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q]  <= addr_i;
      wdata_mem[wr_ptr_q] <= wdata_i;
      be_mem[wr_ptr_q]    <= be_i;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> (used_cnt < store_pkg::SQ_DEPTH));

  a_commit_ready: assert property (
    @(posedge clk_i) disable iff (!rst_ni) commit_i |-> commit_ready_o);

  // Write port holds its request until granted
  a_mem_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_gnt_i) |=> (mem_req_o && $stable(mem_addr_o)
                                   && $stable(mem_wdata_o) && $stable(mem_be_o)));

endmodule

`default_nettype wire

// ==== hw/store_unit.sv ====
// --------------------------------------------------------------------------
// Store unit top, issue control then align then store queue
// Stores are assumed naturally aligned, there is no misalign exception
// --------------------------------------------------------------------------
`default_nettype none

module store_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // Issue stage
  input  logic                             valid_i,
  input  store_pkg::store_op_e             op_i,
  input  logic [store_pkg::VADDR_W-1:0]    vaddr_i,
  input  logic [store_pkg::DATA_W-1:0]     data_i,
  input  logic [store_pkg::TRANS_ID_W-1:0] trans_id_i,
  output logic                             pop_o,
  // Commit
  input  logic                             commit_i,
  output logic                             commit_ready_o,
  // Result
  output logic                             valid_o,
  output logic                             ex_o,
  output logic [store_pkg::TRANS_ID_W-1:0] trans_id_o,
  // MMU
  output logic                             translation_req_o,
  output logic [store_pkg::VADDR_W-1:0]    vaddr_o,
  input  logic [store_pkg::PADDR_W-1:0]    paddr_i,
  input  logic                             dtlb_hit_i,
  input  logic                             ex_valid_i,
  // Queue status
  output logic                             store_buffer_empty_o,
  output logic                             no_st_pending_o,
  // Data memory
  output logic                             mem_req_o,
  output logic [store_pkg::PADDR_W-1:0]    mem_addr_o,
  output logic [store_pkg::DATA_W-1:0]     mem_wdata_o,
  output logic [store_pkg::BE_W-1:0]       mem_be_o,
  input  logic                             mem_gnt_i
);

  logic                          accept_s;
  logic                          push_s;
  logic                          sq_ready_s;
  logic [store_pkg::PADDR_W-1:0] addr_s;
  logic [store_pkg::DATA_W-1:0]  wdata_s;
  logic [store_pkg::BE_W-1:0]    be_s;

  store_ctrl i_store_ctrl (
    .clk_i, .rst_ni, .flush_i, .valid_i, .vaddr_i, .trans_id_i, .pop_o,
    .dtlb_hit_i, .ex_valid_i, .translation_req_o, .vaddr_o,
    .sq_ready_i (sq_ready_s),
    .accept_o   (accept_s),
    .push_o     (push_s),
    .valid_o, .ex_o, .trans_id_o
  );

  // Payload captured in the pop cycle, valid with push
  store_align i_store_align (
    .clk_i, .rst_ni, .op_i, .data_i, .paddr_i,
    .accept_i (accept_s),
    .addr_o   (addr_s),
    .wdata_o  (wdata_s),
    .be_o     (be_s)
  );

  store_queue i_store_queue (
    .clk_i, .rst_ni, .flush_i,
    .push_i  (push_s),
    .addr_i  (addr_s),
    .wdata_i (wdata_s),
    .be_i    (be_s),
    .ready_o (sq_ready_s),
    .commit_i, .commit_ready_o, .store_buffer_empty_o, .no_st_pending_o,
    .mem_req_o, .mem_addr_o, .mem_wdata_o, .mem_be_o, .mem_gnt_i
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the store unit testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_store_unit

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module "$TOP" -f vlog.f -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== test/tb_store_unit.sv ====
// --------------------------------------------------------------------------
// Directed testbench, MMU adds a fixed page offset, memory grants after delay
// Stimulus is driven 1 ns after the rising edge, outputs sampled at negedge
// --------------------------------------------------------------------------
`default_nettype none

module tb_store_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [store_pkg::PADDR_W-1:0] PAGE_OFFS = 34'h2_4000_0000;
  localparam int TIMEOUT = 200;

  typedef struct packed {
    logic [store_pkg::PADDR_W-1:0] addr;
    logic [store_pkg::DATA_W-1:0]  data;
    logic [store_pkg::BE_W-1:0]    be;
  } wr_t;

  logic                             clk_i, rst_ni, flush_i;
  logic                             valid_i, pop_o, commit_i, commit_ready_o;
  store_pkg::store_op_e             op_i;
  logic [store_pkg::VADDR_W-1:0]    vaddr_i, vaddr_o;
  logic [store_pkg::DATA_W-1:0]     data_i, mem_wdata_o;
  logic [store_pkg::TRANS_ID_W-1:0] trans_id_i, trans_id_o;
  logic                             valid_o, ex_o, translation_req_o;
  logic [store_pkg::PADDR_W-1:0]    paddr_i, mem_addr_o;
  logic                             dtlb_hit_i, ex_valid_i;
  logic                             store_buffer_empty_o, no_st_pending_o;
  logic                             mem_req_o, mem_gnt_i;
  logic [store_pkg::BE_W-1:0]       mem_be_o;

  // MMU and memory model controls
  logic miss_force;
  int   gnt_delay, gnt_wait;

  // Scoreboard state
  int   errors, checks, cycle_cnt, pop_total;
  logic pop_q;
  logic [store_pkg::TRANS_ID_W-1:0] next_id;
  logic [store_pkg::TRANS_ID_W:0]   res_q[$];
  wr_t  spec_q[$], exp_writes[$], wr_log[$];

  store_unit dut_i (.*);

  // MMU answers in the same cycle, a miss while forced
  assign paddr_i    = vaddr_o[store_pkg::PADDR_W-1:0] + PAGE_OFFS;
  assign dtlb_hit_i = ~miss_force;

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // --------------------------------------------------------------------------
  // Check helpers and expected write model
  // --------------------------------------------------------------------------
  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond === 1'b1) else begin
      $display("ERROR: %s", msg);
      errors++;
    end
  endtask

  // Word address, data rotated by the byte offset, one enable per written byte
  function automatic wr_t expect_write(input store_pkg::store_op_e op,
                                       input logic [store_pkg::VADDR_W-1:0] vaddr,
                                       input logic [store_pkg::DATA_W-1:0] data);
    wr_t                           w;
    logic [store_pkg::PADDR_W-1:0] paddr;
    int                            offs, nbytes, src;
    paddr  = vaddr[store_pkg::PADDR_W-1:0] + PAGE_OFFS;
    offs   = int'(paddr[2:0]);
    nbytes = 1 << int'(op);
    w.addr = {paddr[store_pkg::PADDR_W-1:3], 3'b000};
    for (int b = 0; b < 8; b++) begin
      src            = (b + 8 - offs) % 8;
      w.data[8*b+:8] = data[8*src+:8];
      w.be[b]        = (b >= offs) && (b < offs + nbytes);
    end
    return w;
  endfunction

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // Outputs of an idle unit right after reset
  task automatic check_reset_state();
    check_val("pop_o", pop_o, 1'b0);
    check_val("valid_o", valid_o, 1'b0);
    check_val("ex_o", ex_o, 1'b0);
    check_val("translation_req_o", translation_req_o, 1'b0);
    check_val("mem_req_o", mem_req_o, 1'b0);
    check_val("commit_ready_o", commit_ready_o, 1'b0);
    check_val("store_buffer_empty_o", store_buffer_empty_o, 1'b1);
    check_val("no_st_pending_o", no_st_pending_o, 1'b1);
  endtask

  // --------------------------------------------------------------------------
  // Models and monitor
  // --------------------------------------------------------------------------
  // Memory grants once req has waited gnt_delay cycles
  always @(posedge clk_i) begin
    #1;
    if (mem_req_o && gnt_wait >= gnt_delay) begin
      mem_gnt_i = 1'b1;
      gnt_wait  = 0;
    end else begin
      mem_gnt_i = 1'b0;
      gnt_wait  = mem_req_o ? gnt_wait + 1 : 0;
    end
  end

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      pop_q = 1'b0;
    end else begin
      // Result strobe exactly one cycle after pop
      check_val("valid_o", valid_o, pop_q);
      if (valid_o) begin
        if (res_q.size() == 0) begin
          check_true(1'b0, "valid_o without an expected result");
        end else begin
          check_val("trans_id_o", trans_id_o, res_q[0][store_pkg::TRANS_ID_W:1]);
          check_val("ex_o", ex_o, res_q[0][0]);
          void'(res_q.pop_front());
        end
      end
      if (pop_o) begin
        res_q.push_back({trans_id_i, ex_valid_i});
        pop_total++;
        if (!ex_valid_i) spec_q.push_back(expect_write(op_i, vaddr_i, data_i));
      end
      pop_q = pop_o;
      // Log every granted write
      if (mem_req_o && mem_gnt_i) wr_log.push_back({mem_addr_o, mem_wdata_o, mem_be_o});
    end
  end

  // --------------------------------------------------------------------------
  // Driver tasks, all start and end 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic start_store(input store_pkg::store_op_e op, input logic [2:0] offs,
                             input logic ex);
    logic [63:0] r;
    r          = {$urandom, $urandom};
    op_i       = op;
    vaddr_i    = {r[store_pkg::VADDR_W-1:3], offs};
    data_i     = {$urandom, $urandom};
    trans_id_i = next_id;
    ex_valid_i = ex;
    valid_i    = 1'b1;
    next_id    = next_id + 1'b1;
  endtask

  // Waits for pop_o, then drops valid_i after the accepting edge
  task automatic wait_pop(output int cyc);
    int n;
    n = 0;
    cyc = 0;
    @(negedge clk_i);
    while (!pop_o && n < TIMEOUT) begin
      check_true(translation_req_o, "translation_req_o low while a store waits");
      @(negedge clk_i);
      n++;
    end
    if (!pop_o) begin
      check_true(1'b0, "timeout waiting for pop_o");
      end_run();
    end else begin
      // The MMU sees the address of the store being accepted
      check_val("vaddr_o", vaddr_o, vaddr_i);
      cyc = cycle_cnt;
      @(posedge clk_i);
      #1;
      valid_i    = 1'b0;
      ex_valid_i = 1'b0;
    end
  endtask

  // The held store must not be popped for n cycles
  task automatic hold_no_pop(input int n);
    repeat (n) begin
      @(negedge clk_i);
      check_val("pop_o", pop_o, 1'b0);
      check_val("translation_req_o", translation_req_o, 1'b1);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic commit_one();
    int n;
    n = 0;
    while (!commit_ready_o && n < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (!commit_ready_o || spec_q.size() == 0) begin
      check_true(1'b0, "timeout waiting for a store to commit");
      end_run();
    end else begin
      commit_i = 1'b1;
      exp_writes.push_back(spec_q.pop_front());
      @(posedge clk_i);
      #1;
      commit_i = 1'b0;
    end
  endtask

  // no_st_pending_o may only rise once every committed write is granted
  task automatic wait_drained();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!no_st_pending_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!no_st_pending_o) begin
      check_true(1'b0, "timeout waiting for the queue to drain");
      end_run();
    end else begin
      check_true(wr_log.size() == exp_writes.size(),
                 "no_st_pending_o rose before the last grant");
      // Nothing committed is left to request
      check_val("mem_req_o", mem_req_o, 1'b0);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_writes();
    check_val("write count", wr_log.size(), exp_writes.size());
    for (int i = 0; i < wr_log.size() && i < exp_writes.size(); i++) begin
      check_val("mem_addr_o", wr_log[i].addr, exp_writes[i].addr);
      check_val("mem_wdata_o", wr_log[i].data, exp_writes[i].data);
      check_val("mem_be_o", wr_log[i].be, exp_writes[i].be);
    end
    wr_log.delete();
    exp_writes.delete();
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_alignment();
    int c;
    for (int k = 0; k < 4; k++) begin
      for (int offs = 0; offs < 8; offs += (1 << k)) begin
        start_store(store_pkg::store_op_e'(k), 3'(offs), 1'b0);
        wait_pop(c);
        commit_one();
      end
    end
    wait_drained();
    check_writes();
  endtask

  task automatic test_back_to_back();
    int c0, c1, c2;
    start_store(store_pkg::ST_D, 3'd0, 1'b0);
    wait_pop(c0);
    start_store(store_pkg::ST_W, 3'd4, 1'b0);
    wait_pop(c1);
    start_store(store_pkg::ST_H, 3'd2, 1'b0);
    wait_pop(c2);
    check_val("pop_o cycle", c1, c0 + 1);
    check_val("pop_o cycle", c2, c1 + 1);
    repeat (3) commit_one();
    wait_drained();
    check_writes();
  endtask

  task automatic test_tlb_miss();
    int c, pops;
    miss_force = 1'b1;
    start_store(store_pkg::ST_W, 3'd0, 1'b0);
    pops = pop_total;
    hold_no_pop(6);
    miss_force = 1'b0;
    wait_pop(c);
    idle(3);
    check_val("pop count", pop_total - pops, 1);
    commit_one();
    wait_drained();
    check_writes();
  endtask

  task automatic test_queue_full();
    int c;
    for (int i = 0; i < 4; i++) begin
      start_store(store_pkg::ST_D, 3'd0, 1'b0);
      wait_pop(c);
    end
    // Fifth store finds no free entry
    start_store(store_pkg::ST_B, 3'd5, 1'b0);
    hold_no_pop(6);
    commit_one();
    wait_pop(c);
    repeat (4) commit_one();
    wait_drained();
    check_writes();
  endtask

  task automatic test_flush_ex();
    int c;
    // Faulting store answers with ex_o and never reaches the queue
    start_store(store_pkg::ST_W, 3'd4, 1'b1);
    wait_pop(c);
    idle(3);
    check_val("store_buffer_empty_o", store_buffer_empty_o, 1'b1);
    check_val("commit_ready_o", commit_ready_o, 1'b0);
    // Slow grant keeps the committed store pending across the flush
    gnt_delay = 6;
    start_store(store_pkg::ST_D, 3'd0, 1'b0);
    wait_pop(c);
    start_store(store_pkg::ST_H, 3'd6, 1'b0);
    wait_pop(c);
    commit_one();
    start_store(store_pkg::ST_B, 3'd3, 1'b0);
    wait_pop(c);
    idle(2);
    check_val("no_st_pending_o", no_st_pending_o, 1'b0);
    flush_i = 1'b1;
    spec_q.delete();
    idle(1);
    flush_i = 1'b0;
    wait_drained();
    check_writes();
    check_val("store_buffer_empty_o", store_buffer_empty_o, 1'b1);
    gnt_delay = 0;
  endtask

  task automatic test_gnt_delay();
    int c;
    gnt_delay = 3;
    for (int i = 0; i < 4; i++) begin
      start_store(store_pkg::store_op_e'(i), 3'd0, 1'b0);
      wait_pop(c);
    end
    repeat (4) commit_one();
    wait_drained();
    check_writes();
    gnt_delay = 0;
  endtask

  initial begin
    void'($urandom(51));
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    valid_i    = 1'b0;
    op_i       = store_pkg::ST_B;
    vaddr_i    = '0;
    data_i     = '0;
    trans_id_i = '0;
    ex_valid_i = 1'b0;
    commit_i   = 1'b0;
    mem_gnt_i  = 1'b0;
    miss_force = 1'b0;
    gnt_delay  = 0;
    gnt_wait   = 0;
    errors     = 0;
    checks     = 0;
    cycle_cnt  = 0;
    pop_total  = 0;
    next_id    = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    idle(2);
    check_reset_state();

    test_alignment();
    test_back_to_back();
    test_tlb_miss();
    test_queue_full();
    test_flush_ex();
    test_gnt_delay();

    idle(3);
    check_true(res_q.size() == 0, "result strobes missing at the end of the run");
    check_val("store_buffer_empty_o", store_buffer_empty_o, 1'b1);
    end_run();
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/store_pkg.sv
hw/store_ctrl.sv
hw/store_align.sv
hw/store_queue.sv
hw/store_unit.sv
test/tb_store_unit.sv
